/* bench/cc_ctrl_properties.sv */
// Bound checker for the control-register subsystem
// Shadow of the read/write registers, expected read data and write response
// Concurrent assertions on AXI timing, register ports and the scan counter
`timescale 1ns/1ps
`include "cc_ctrl_params.svh"

module cc_ctrl_properties (
  input logic clk, rst_n,
  input logic [`CC_AXI_ADDR_W-1:0] awaddr, araddr,
  input logic awvalid, awready, wvalid, wready, bvalid, bready,
  input logic arvalid, arready, rvalid, rready,
  input logic [`CC_AXI_DATA_W-1:0] wdata, rdata,
  input logic [3:0] wstrb,
  input logic [1:0] bresp, rresp,
  input logic [15:0] mode_ctrl, mem_ctrl, output_ctrl, sprite_z, scroll_x, scroll_y,
  input logic [15:0] tile_ctrl0, tile_data_offset, tile_nop_value, tile_color_key,
  input logic [15:0] tile_offset_x, tile_offset_y,
  input logic [15:0] scan_x, scan_y,
  input logic hblank, vblank
);

  localparam logic [15:0] H_LAST = 16'(`CC_H_TOTAL - 1);
  localparam logic [15:0] V_LAST = 16'(`CC_V_TOTAL - 1);

  logic [15:0] shadow [32];    // Expected content of every index
  logic [15:0] port_val [32];  // Top-level value ports by index
  logic [4:0]  rd_idx;
  logic [15:0] exp_rdata;
  logic [1:0]  exp_bresp;
  logic        wr_pend;        // Cycle after a write handshake, register not yet updated
  logic        rd_pend;
  logic        wr_hs, rd_hs;
  logic [4:0]  wr_idx;
  int          fail_count = 0;  // Failed assertions so far

  // Writable indices of both maps
  function automatic logic is_rw(input int idx);
    return (idx >= 4 && idx <= 9) || (idx >= 16 && idx <= 21);
  endfunction

  function automatic string reg_name(input int idx);
    case (idx)
      4: return "mode_ctrl";
      5: return "mem_ctrl";
      6: return "output_ctrl";
      7: return "sprite_z";
      8: return "scroll_x";
      9: return "scroll_y";
      16: return "tile_ctrl0";
      17: return "tile_data_offset";
      18: return "tile_nop_value";
      19: return "tile_color_key";
      20: return "tile_offset_x";
      default: return "tile_offset_y";
    endcase
  endfunction

  assign wr_hs  = awvalid && awready && wvalid && wready;
  assign rd_hs  = arvalid && arready;
  assign wr_idx = awaddr[6:2];

  always_comb begin
    for (int i = 0; i < 32; i++) port_val[i] = '0;
    port_val[`CC_MODE_CTRL]        = mode_ctrl;
    port_val[`CC_MEM_CTRL]         = mem_ctrl;
    port_val[`CC_OUTPUT_CTRL]      = output_ctrl;
    port_val[`CC_SPRITE_Z]         = sprite_z;
    port_val[`CC_SCROLL_X]         = scroll_x;
    port_val[`CC_SCROLL_Y]         = scroll_y;
    port_val[`CC_TILE_CTRL0]       = tile_ctrl0;
    port_val[`CC_TILE_DATA_OFFSET] = tile_data_offset;
    port_val[`CC_TILE_NOP_VALUE]   = tile_nop_value;
    port_val[`CC_TILE_COLOR_KEY]   = tile_color_key;
    port_val[`CC_TILE_OFFSET_X]    = tile_offset_x;
    port_val[`CC_TILE_OFFSET_Y]    = tile_offset_y;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) shadow[i] <= '0;
      rd_idx    <= '0;
      exp_rdata <= '0;
      exp_bresp <= cc_ctrl_pkg::RESP_OKAY;
      wr_pend   <= 1'b0;
      rd_pend   <= 1'b0;
    end else begin
      wr_pend <= wr_hs;
      rd_pend <= rd_hs;
      if (wr_hs) begin
        if (is_rw(int'(wr_idx))) begin
          if (wstrb[0]) shadow[wr_idx][7:0] <= wdata[7:0];
          if (wstrb[1]) shadow[wr_idx][15:8] <= wdata[15:8];
          exp_bresp <= cc_ctrl_pkg::RESP_OKAY;
        end else begin
          exp_bresp <= cc_ctrl_pkg::RESP_SLVERR;  // Read-only or unmapped
        end
      end
      if (rd_hs) rd_idx <= araddr[6:2];
      if (rd_pend) begin  // Live values at the read strobe
        case (rd_idx)
          5'd0: exp_rdata <= `CC_ID_VALUE;
          5'd1: exp_rdata <= {14'b0, hblank, vblank};
          5'd2: exp_rdata <= scan_x;
          5'd3: exp_rdata <= scan_y;
          default: exp_rdata <= shadow[rd_idx];  // Zero where nothing is mapped
        endcase
      end
    end
  end

  for (genvar g = 0; g < 32; g++) begin : g_port
    if (is_rw(g)) begin : g_rw
      assert property (@(posedge clk) disable iff (!rst_n) !wr_pend |-> port_val[g] == shadow[g])
        else begin
          $error("Fail %0t %s exp %h act %h", $time, reg_name(g), shadow[g], port_val[g]);
          fail_count++;
        end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) wr_hs |=> !bvalid ##1 bvalid)
    else begin
      $error("bvalid did not rise two cycles after the write handshake at %0t", $time);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) rd_hs |=> !rvalid ##1 rvalid)
    else begin
      $error("rvalid did not rise two cycles after the read handshake at %0t", $time);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !$past(bvalid) |-> bresp == exp_bresp)
    else begin
      $error("Fail %0t bresp exp %h act %h", $time, exp_bresp, bresp);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !$past(rvalid) |-> rdata == {16'b0, exp_rdata})
    else begin
      $error("Fail %0t rdata exp %h act %h", $time, {16'b0, exp_rdata}, rdata);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> rresp == 2'b00)
    else begin
      $error("Fail %0t rresp exp %h act %h", $time, 2'b00, rresp);
      fail_count++;
    end
  // Back-pressure holds the response and keeps every ready low
  assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("Write response changed under back-pressure at %0t", $time);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
      $error("Read response changed under back-pressure at %0t", $time);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    bvalid || rvalid |-> !awready && !wready && !arready)
    else begin
      $error("A ready output was high during a response at %0t", $time);
      fail_count++;
    end

  // Scan counter
  assert property (@(posedge clk) disable iff (!rst_n)
    output_ctrl[0] |=> scan_x == (($past(scan_x) == H_LAST) ? 16'd0 : $past(scan_x) + 16'd1))
    else begin
      $error("Fail %0t scan_x exp %h act %h", $time,
             ($past(scan_x) == H_LAST) ? 16'd0 : $past(scan_x) + 16'd1, scan_x);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) output_ctrl[0] && scan_x == H_LAST
    |=> scan_y == (($past(scan_y) == V_LAST) ? 16'd0 : $past(scan_y) + 16'd1))
    else begin
      $error("Fail %0t scan_y exp %h act %h", $time,
             ($past(scan_y) == V_LAST) ? 16'd0 : $past(scan_y) + 16'd1, scan_y);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) output_ctrl[0] && scan_x != H_LAST
    |=> $stable(scan_y))
    else begin
      $error("Fail %0t scan_y exp %h act %h", $time, $past(scan_y), scan_y);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n)
    !output_ctrl[0] |=> scan_x == 0 && scan_y == 0)
    else begin
      $error("Scan counters not cleared after output disable at %0t", $time);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) hblank == (scan_x >= `CC_H_VISIBLE))
    else begin
      $error("Fail %0t hblank exp %b act %b", $time, scan_x >= `CC_H_VISIBLE, hblank);
      fail_count++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) vblank == (scan_y >= `CC_V_VISIBLE))
    else begin
      $error("Fail %0t vblank exp %b act %b", $time, scan_y >= `CC_V_VISIBLE, vblank);
      fail_count++;
    end

endmodule

bind cc_ctrl_top cc_ctrl_properties props_i (
  .clk, .rst_n, .awaddr, .araddr, .awvalid, .awready, .wvalid, .wready,
  .bvalid, .bready, .arvalid, .arready, .rvalid, .rready, .wdata, .rdata,
  .wstrb, .bresp, .rresp, .mode_ctrl, .mem_ctrl, .output_ctrl, .sprite_z,
  .scroll_x, .scroll_y, .tile_ctrl0, .tile_data_offset, .tile_nop_value,
  .tile_color_key, .tile_offset_x, .tile_offset_y, .scan_x, .scan_y, .hblank, .vblank
);

/* bench/cc_ctrl_tb.sv */
// Testbench for the control-register subsystem
// Clock, reset, AXI4-Lite write and read tasks, LFSR stimulus, watchdog
`timescale 1ns/1ps
`include "cc_ctrl_params.svh"

module cc_ctrl_tb;

  logic        clk, rst_n;
  logic [7:0]  awaddr, araddr;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        awready, wready, bvalid, arready, rvalid;
  logic [1:0]  bresp, rresp;
  logic [31:0] rdata;
  logic [15:0] mode_ctrl, mem_ctrl, output_ctrl, sprite_z, scroll_x, scroll_y;
  logic [15:0] tile_ctrl0, tile_data_offset, tile_nop_value, tile_color_key;
  logic [15:0] tile_offset_x, tile_offset_y, scan_x, scan_y;
  logic        hblank, vblank;

  logic [15:0] lfsr = 16'd39;  // Seed
  logic        passed = 1'b0;
  logic        fail_shown = 1'b0;

  cc_ctrl_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps 16, 14, 13, 11; one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int delay;
    delay   = int'(rand_bits(2));  // bready back-pressure
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);  // Handshake done at the edge before
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    repeat (delay) @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr);
    int delay;
    delay   = int'(rand_bits(2));
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    repeat (delay) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Read whose response is pending while a write already waits on the bus
  task automatic read_with_pending_write(input logic [7:0] raddr, input logic [7:0] waddr,
                                         input logic [31:0] data, input logic [3:0] strb);
    int delay;
    delay   = int'(rand_bits(2));
    araddr  = raddr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    awaddr  = waddr;  // Not accepted before the read response is taken
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!rvalid) @(negedge clk);
    repeat (delay) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    axi_write(waddr, data, strb);  // Same write, taken once the slave is idle
  endtask

  initial begin
    logic [7:0] addr;
    rst_n = 1'b0;
    {awaddr, araddr, awvalid, wvalid, bready, arvalid, rready, wdata, wstrb} = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Write and read back every index, ID, status and unmapped ones included
    for (int i = 0; i < 32; i++) begin
      axi_write(8'(i << 2), {16'(rand_bits(16)), 16'(rand_bits(16))}, 4'(rand_bits(4)));
      axi_read(8'(i << 2));
    end
    // Random index, data and strobes, each write read back
    for (int i = 0; i < 60; i++) begin
      addr = {1'b0, 5'(rand_bits(5)), 2'b00};
      axi_write(addr, {16'(rand_bits(16)), 16'(rand_bits(16))}, 4'(rand_bits(4)));
      axi_read(addr);
    end
    // Writes held off by a read response in flight
    for (int i = 0; i < 8; i++) begin
      addr = {1'b0, 5'(rand_bits(5)), 2'b00};
      read_with_pending_write(addr, {1'b0, 5'(rand_bits(5)), 2'b00},
                              {16'(rand_bits(16)), 16'(rand_bits(16))}, 4'(rand_bits(4)));
    end
    // Output enabled for about three frames
    axi_write(8'(`CC_OUTPUT_CTRL << 2), 32'h1, 4'h3);
    for (int i = 0; i < 30; i++) begin
      axi_read(8'(`CC_OUTPUT_STATUS << 2));
      axi_read(8'(`CC_SCAN_X << 2));
    end
    axi_write(8'(`CC_OUTPUT_CTRL << 2), 32'h0, 4'h3);
    repeat (4) @(negedge clk);
    if (dut_i.props_i.fail_count == 0) begin
      passed = 1'b1;
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      fail_shown = 1'b1;
      $display("CHECKS FAILED");
      $fatal(1, "The checker saw %0d failed assertions", dut_i.props_i.fail_count);
    end
  end

  // Watch the bound checker for a failed assertion
  initial begin
    wait (dut_i.props_i.fail_count != 0);
    fail_shown = 1'b1;
    $display("CHECKS FAILED");
    $fatal(1, "An assertion failed at %0t", $time);
  end

  // About 260 transactions of up to 6 cycles, at most 1600 cycles at 20 ns
  initial begin
    #60us;
    $display("Timeout, the run did not complete within 60 us");
    fail_shown = 1'b1;
    $display("CHECKS FAILED");
    $fatal(1, "Watchdog expired");
  end

  final begin
    if (!passed && !fail_shown) begin
      $display("CHECKS FAILED");
    end
  end

endmodule

/* cc_ctrl.f */
+incdir+include
hw/cc_ctrl_pkg.sv
hw/reg_bus_if.sv
hw/cc_axil_slave.sv
hw/cc_register_file.sv
hw/cc_scan_timing.sv
hw/cc_ctrl_top.sv
bench/cc_ctrl_properties.sv
bench/cc_ctrl_tb.sv

/* hw/cc_axil_slave.sv */
// AXI4-Lite slave for the control registers
// One transaction at a time, each turned into a single register-bus strobe
// Writes win over a read arriving in the same cycle
`timescale 1ns/1ps
`include "cc_ctrl_params.svh"

module cc_axil_slave (
  input  logic                      clk,
  input  logic                      rst_n,
  // Write address and data
  input  logic [`CC_AXI_ADDR_W-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`CC_AXI_DATA_W-1:0] wdata,
  input  logic [3:0]                wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  // Write response
  output logic                      bvalid,
  input  logic                      bready,
  output logic [1:0]                bresp,
  // Read address
  input  logic [`CC_AXI_ADDR_W-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  // Read data
  output logic                      rvalid,
  input  logic                      rready,
  output logic [1:0]                rresp,
  output logic [`CC_AXI_DATA_W-1:0] rdata,
  reg_bus_if.host                   bus
);

  cc_ctrl_pkg::axil_state_e state, state_nxt;
  cc_ctrl_pkg::axi_resp_e   bresp_q;

  logic [`CC_REG_IDX_W-1:0] idx_q;    // Register index of the current access
  logic [`CC_REG_W-1:0]     wdata_q;
  logic [1:0]               be_q;
  logic [`CC_REG_W-1:0]     rdata_q;  // Held for the whole read response

  logic wr_hs;
  logic ar_hs;

  // Address and data are taken together, never one without the other
  assign awready = (state == cc_ctrl_pkg::S_IDLE) && awvalid && wvalid;
  assign wready  = awready;
  assign wr_hs   = awready;

  // A half-presented write still blocks the read channel
  assign arready = (state == cc_ctrl_pkg::S_IDLE) && !awvalid && !wvalid;
  assign ar_hs   = arvalid && arready;

  always_comb begin
    state_nxt = state;
    case (state)
      cc_ctrl_pkg::S_IDLE: begin
        if (wr_hs) begin
          state_nxt = cc_ctrl_pkg::S_WR_ACCESS;
        end else if (ar_hs) begin
          state_nxt = cc_ctrl_pkg::S_RD_ACCESS;
        end
      end
      cc_ctrl_pkg::S_WR_ACCESS: state_nxt = cc_ctrl_pkg::S_WR_RESP;
      cc_ctrl_pkg::S_WR_RESP:   if (bready) state_nxt = cc_ctrl_pkg::S_IDLE;
      cc_ctrl_pkg::S_RD_ACCESS: state_nxt = cc_ctrl_pkg::S_RD_RESP;
      cc_ctrl_pkg::S_RD_RESP:   if (rready) state_nxt = cc_ctrl_pkg::S_IDLE;
      default:                  state_nxt = cc_ctrl_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= cc_ctrl_pkg::S_IDLE;
      bresp_q <= cc_ctrl_pkg::RESP_OKAY;
    end else begin
      state <= state_nxt;
      if (state == cc_ctrl_pkg::S_WR_ACCESS) begin  // err is valid during the strobe
        bresp_q <= bus.err ? cc_ctrl_pkg::RESP_SLVERR : cc_ctrl_pkg::RESP_OKAY;
      end
    end
  end

  // Request payload and read data
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      idx_q   <= awaddr[`CC_REG_IDX_W+1:2];       // Word index, byte offset dropped
      wdata_q <= wdata[`CC_REG_W-1:0];
      be_q    <= wstrb[1:0];                       // Upper lanes hold no register bits
    end else if (ar_hs) begin
      idx_q <= araddr[`CC_REG_IDX_W+1:2];
    end
    if (state == cc_ctrl_pkg::S_RD_ACCESS) begin
      rdata_q <= bus.rdata;
    end
  end

  // Register-bus strobes come straight from the state
  assign bus.wr    = (state == cc_ctrl_pkg::S_WR_ACCESS);
  assign bus.rd    = (state == cc_ctrl_pkg::S_RD_ACCESS);
  assign bus.idx   = idx_q;
  assign bus.wdata = wdata_q;
  assign bus.be    = be_q;

  assign bvalid = (state == cc_ctrl_pkg::S_WR_RESP);
  assign bresp  = bresp_q;
  assign rvalid = (state == cc_ctrl_pkg::S_RD_RESP);
  assign rresp  = cc_ctrl_pkg::RESP_OKAY;                // Every index is readable
  assign rdata  = {{(`CC_AXI_DATA_W-`CC_REG_W){1'b0}}, rdata_q};

endmodule

/* hw/cc_ctrl_pkg.sv */
// Types for the control-register subsystem
// Register access kinds, AXI slave states, AXI response codes
// Access-type lookup per register index
`include "cc_ctrl_params.svh"

package cc_ctrl_pkg;

  typedef enum logic {
    REG_RW,
    REG_RO
  } reg_access_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WR_ACCESS,  // Write strobe cycle
    S_WR_RESP,
    S_RD_ACCESS,  // Read strobe cycle
    S_RD_RESP
  } axil_state_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // Only the listed indices are writable
  // Anything else counts as read-only, unmapped ones read as zero
  function automatic reg_access_e reg_access_of(input logic [`CC_REG_IDX_W-1:0] idx);
    reg_access_e acc;
    case (idx)
      `CC_MODE_CTRL, `CC_MEM_CTRL, `CC_OUTPUT_CTRL,
      `CC_SPRITE_Z, `CC_SCROLL_X, `CC_SCROLL_Y:     acc = REG_RW;
      `CC_TILE_CTRL0, `CC_TILE_DATA_OFFSET,
      `CC_TILE_NOP_VALUE, `CC_TILE_COLOR_KEY,
      `CC_TILE_OFFSET_X, `CC_TILE_OFFSET_Y:         acc = REG_RW;
      default:                                      acc = REG_RO;
    endcase
    return acc;
  endfunction

endpackage

/* hw/cc_ctrl_top.sv */
// Top level of the control-register subsystem
// AXI4-Lite slave, register file and scan counter on plain ports
`timescale 1ns/1ps
`include "cc_ctrl_params.svh"

module cc_ctrl_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // AXI4-Lite slave port
  input  logic [`CC_AXI_ADDR_W-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`CC_AXI_DATA_W-1:0] wdata,
  input  logic [3:0]                wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic                      bvalid,
  input  logic                      bready,
  output logic [1:0]                bresp,
  input  logic [`CC_AXI_ADDR_W-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic                      rvalid,
  input  logic                      rready,
  output logic [1:0]                rresp,
  output logic [`CC_AXI_DATA_W-1:0] rdata,
  // Register values
  output logic [15:0]               mode_ctrl,
  output logic [15:0]               mem_ctrl,
  output logic [15:0]               output_ctrl,
  output logic [15:0]               sprite_z,
  output logic [15:0]               scroll_x,
  output logic [15:0]               scroll_y,
  output logic [15:0]               tile_ctrl0,
  output logic [15:0]               tile_data_offset,
  output logic [15:0]               tile_nop_value,
  output logic [15:0]               tile_color_key,
  output logic [15:0]               tile_offset_x,
  output logic [15:0]               tile_offset_y,
  // Scan position and status
  output logic [15:0]               scan_x,
  output logic [15:0]               scan_y,
  output logic                      hblank,
  output logic                      vblank
);

  reg_bus_if u_bus ();  // Slave to register file

  cc_axil_slave u_axil (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bvalid, .bready, .bresp,
    .araddr, .arvalid, .arready, .rvalid, .rready, .rresp, .rdata,
    .bus (u_bus.host)
  );

  cc_register_file u_regs (
    .clk, .rst_n,
    .bus (u_bus.target),
    .scan_x, .scan_y, .hblank, .vblank,
    .mode_ctrl, .mem_ctrl, .output_ctrl, .sprite_z, .scroll_x, .scroll_y,
    .tile_ctrl0, .tile_data_offset, .tile_nop_value, .tile_color_key,
    .tile_offset_x, .tile_offset_y
  );

  cc_scan_timing u_scan (
    .clk, .rst_n,
    .enable (output_ctrl[0]),  // Output enable bit
    .scan_x, .scan_y, .hblank, .vblank
  );

endmodule

/* hw/cc_register_file.sv */
// Main and tile register maps behind the register bus
// Byte-enabled read/write storage, read multiplexer, write error flag
`timescale 1ns/1ps
`include "cc_ctrl_params.svh"

module cc_register_file (
  input  logic                clk,
  input  logic                rst_n,
  reg_bus_if.target           bus,
  // Live values for the read-only registers
  input  logic [15:0]         scan_x,
  input  logic [15:0]         scan_y,
  input  logic                hblank,
  input  logic                vblank,
  // Main map read/write values
  output logic [15:0]         mode_ctrl,
  output logic [15:0]         mem_ctrl,
  output logic [15:0]         output_ctrl,
  output logic [15:0]         sprite_z,
  output logic [15:0]         scroll_x,
  output logic [15:0]         scroll_y,
  // Tile map read/write values
  output logic [15:0]         tile_ctrl0,
  output logic [15:0]         tile_data_offset,
  output logic [15:0]         tile_nop_value,
  output logic [15:0]         tile_color_key,
  output logic [15:0]         tile_offset_x,
  output logic [15:0]         tile_offset_y
);

  localparam int NUM_IDX = 2 ** `CC_REG_IDX_W;

  // Whole index space, only writable entries ever leave zero
  logic [`CC_REG_W-1:0] regs [NUM_IDX];

  cc_ctrl_pkg::reg_access_e access;
  logic                     wr_ok;

  assign access = cc_ctrl_pkg::reg_access_of(bus.idx);
  assign wr_ok  = bus.wr && !bus.rd && (access == cc_ctrl_pkg::REG_RW);
  assign bus.err = (access == cc_ctrl_pkg::REG_RO);  // Slave only samples it on writes

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_IDX; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      if (bus.be[0]) regs[bus.idx][7:0]  <= bus.wdata[7:0];   // Low byte
      if (bus.be[1]) regs[bus.idx][15:8] <= bus.wdata[15:8];  // High byte
    end
  end

  // Read mux, read-only values are sampled live
  always_comb begin
    case (bus.idx)
      `CC_ID:            bus.rdata = `CC_ID_VALUE;
      `CC_OUTPUT_STATUS: bus.rdata = {14'b0, hblank, vblank};
      `CC_SCAN_X:        bus.rdata = scan_x;
      `CC_SCAN_Y:        bus.rdata = scan_y;
      default: begin
        // Unmapped indices give zero
        bus.rdata = (access == cc_ctrl_pkg::REG_RW) ? regs[bus.idx] : '0;
      end
    endcase
  end

  assign mode_ctrl        = regs[`CC_MODE_CTRL];
  assign mem_ctrl         = regs[`CC_MEM_CTRL];
  assign output_ctrl      = regs[`CC_OUTPUT_CTRL];  // Bit 0 enables scan
  assign sprite_z         = regs[`CC_SPRITE_Z];
  assign scroll_x         = regs[`CC_SCROLL_X];
  assign scroll_y         = regs[`CC_SCROLL_Y];
  assign tile_ctrl0       = regs[`CC_TILE_CTRL0];
  assign tile_data_offset = regs[`CC_TILE_DATA_OFFSET];
  assign tile_nop_value   = regs[`CC_TILE_NOP_VALUE];
  assign tile_color_key   = regs[`CC_TILE_COLOR_KEY];
  assign tile_offset_x    = regs[`CC_TILE_OFFSET_X];
  assign tile_offset_y    = regs[`CC_TILE_OFFSET_Y];

endmodule

/* hw/cc_scan_timing.sv */
// Scan position counter for the output raster
// Horizontal and vertical wrapping counters plus blanking decode
`timescale 1ns/1ps
`include "cc_ctrl_params.svh"

module cc_scan_timing (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,   // Output enable from the control register
  output logic [15:0] scan_x,
  output logic [15:0] scan_y,
  output logic        hblank,
  output logic        vblank
);

  localparam logic [15:0] H_LAST = 16'(`CC_H_TOTAL - 1);
  localparam logic [15:0] V_LAST = 16'(`CC_V_TOTAL - 1);
  localparam logic [15:0] H_VIS  = 16'(`CC_H_VISIBLE);
  localparam logic [15:0] V_VIS  = 16'(`CC_V_VISIBLE);

  logic h_wrap;

  assign h_wrap = (scan_x == H_LAST);  // End of line

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_x <= '0;
      scan_y <= '0;
    end else if (!enable) begin
      // Held at the frame origin while output is off
      scan_x <= '0;
      scan_y <= '0;
    end else begin
      if (h_wrap) begin
        scan_x <= '0;
        if (scan_y == V_LAST) begin
          scan_y <= '0;              // End of frame
        end else begin
          scan_y <= scan_y + 16'd1;
        end
      end else begin
        scan_x <= scan_x + 16'd1;
      end
    end
  end

  // Blanking past the visible area
  assign hblank = (scan_x >= H_VIS);
  assign vblank = (scan_y >= V_VIS);

endmodule

/* hw/reg_bus_if.sv */
// Internal register bus between the AXI slave and the register file
// Single-cycle wr and rd strobes, combinational read data and error
`timescale 1ns/1ps
`include "cc_ctrl_params.svh"

interface reg_bus_if;

  logic                     wr;     // One-cycle write strobe
  logic                     rd;     // One-cycle read strobe
  logic [`CC_REG_IDX_W-1:0] idx;    // Map select plus register number
  logic [`CC_REG_W-1:0]     wdata;
  logic [1:0]               be;     // Byte enables, bit 0 is the low byte
  logic [`CC_REG_W-1:0]     rdata;  // Follows idx without a clock
  logic                     err;    // idx is not writable

  // AXI side
  modport host (
    output wr, rd, idx, wdata, be,
    input  rdata, err
  );

  // Register file side
  modport target (
    input  wr, rd, idx, wdata, be,
    output rdata, err
  );

endinterface

/* include/cc_ctrl_params.svh */
// Shared sizes for the control-register subsystem
// AXI and register widths, register indices, ID word, scan dimensions
`ifndef CC_CTRL_PARAMS_SVH
`define CC_CTRL_PARAMS_SVH

`define CC_AXI_ADDR_W 8        // Byte address
`define CC_AXI_DATA_W 32
`define CC_REG_W      16
`define CC_REG_IDX_W  5        // Bit 4 picks the tile map, taken from addr[6:2]

// Main map
`define CC_ID               0
`define CC_OUTPUT_STATUS    1
`define CC_SCAN_X           2
`define CC_SCAN_Y           3
`define CC_MODE_CTRL        4
`define CC_MEM_CTRL         5
`define CC_OUTPUT_CTRL      6
`define CC_SPRITE_Z         7
`define CC_SCROLL_X         8
`define CC_SCROLL_Y         9

// Tile map
`define CC_TILE_CTRL0       16
`define CC_TILE_DATA_OFFSET 17
`define CC_TILE_NOP_VALUE   18
`define CC_TILE_COLOR_KEY   19
`define CC_TILE_OFFSET_X    20
`define CC_TILE_OFFSET_Y    21

`define CC_ID_VALUE 16'h4343

// Scan raster, kept tiny so a frame is short
`define CC_H_TOTAL   16
`define CC_H_VISIBLE 12
`define CC_V_TOTAL   8
`define CC_V_VISIBLE 6

`endif

/* run.sh */
#!/bin/sh
# Build and run the control-register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing \
  -f cc_ctrl.f \
  --top-module cc_ctrl_tb \
  -o cc_ctrl_sim

./obj_dir/cc_ctrl_sim
